/* Bender.yml */
package:
  name: pic_control_logic

sources:
  - files:
      - design/pic_pkg.sv
      - design/pic_command_decode.sv
      - design/pic_mode_registers.sv
      - design/pic_acknowledge_sequencer.sv
      - design/pic_data_output.sv
      - design/pic_control_logic.sv
  - target: simulation
    files:
      - sim/tb_pic_control_logic.sv

/* design/pic_acknowledge_sequencer.sv */
// ****************************************
// PIC acknowledge sequencer
// INTA and poll FSM, INT to the CPU, freeze,
// in-service latching and request clearing
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module pic_acknowledge_sequencer (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         icw1,
    input  wire logic         ocw3,
    input  wire logic         ocw3_poll,
    input  wire logic         interrupt_acknowledge_n,
    input  wire logic         read,
    input  wire logic [7:0]   interrupt,
    output pic_pkg::ack_phase_t phase,
    output logic [7:0]        acknowledged,
    output logic              end_of_ack,
    output logic              interrupt_to_cpu,
    output logic              latch_in_service,
    output logic              freeze,
    output logic [7:0]        clear_interrupt_request
);

    pic_pkg::ack_phase_t next_phase;
    logic                previous_ack_n;
    logic                previous_read;
    logic                ack_falling;
    logic                ack_rising;
    logic                read_falling;
    logic                end_of_poll;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            previous_ack_n <= 1'b1;
            previous_read <= 1'b0;
        end else begin
            previous_ack_n <= interrupt_acknowledge_n;
            previous_read <= read;
        end
    end

    assign ack_falling = previous_ack_n & ~interrupt_acknowledge_n;
    assign ack_rising = ~previous_ack_n & interrupt_acknowledge_n;
    assign read_falling = previous_read & ~read;

    always_comb begin
        next_phase = phase;
        case (phase)
            pic_pkg::phase_ready: begin
                if (ocw3 && ocw3_poll)
                    next_phase = pic_pkg::phase_poll;
                else if (ack_falling)
                    next_phase = pic_pkg::phase_ack1;
            end
            pic_pkg::phase_ack1: if (ack_rising) next_phase = pic_pkg::phase_ack2;
            pic_pkg::phase_ack2: if (ack_rising) next_phase = pic_pkg::phase_ready;
            pic_pkg::phase_poll: if (read_falling) next_phase = pic_pkg::phase_ready;
            default: next_phase = pic_pkg::phase_ready;
        endcase
    end

    assign end_of_ack = (phase == pic_pkg::phase_ack2) & ack_rising;
    assign end_of_poll = (phase == pic_pkg::phase_poll) & read_falling;

    assign latch_in_service = ~icw1 & (phase == pic_pkg::phase_ready)
                            & (next_phase != pic_pkg::phase_ready);

    always_comb begin
        if (icw1)
            clear_interrupt_request = '1;
        else if (latch_in_service)
            clear_interrupt_request = interrupt;
        else
            clear_interrupt_request = '0;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= pic_pkg::phase_ready;
            acknowledged <= '0;
            interrupt_to_cpu <= 1'b0;
            freeze <= 1'b1;
        end else if (icw1) begin
            phase <= pic_pkg::phase_ready;
            acknowledged <= '0;
            interrupt_to_cpu <= 1'b0;
            freeze <= 1'b0;
        end else begin
            phase <= next_phase;
            freeze <= (next_phase != pic_pkg::phase_ready);
            // Keep a single level even if several requests show up together
            if (latch_in_service)
                acknowledged <= (interrupt == '0) ? '0
                              : pic_pkg::level_to_onehot(pic_pkg::onehot_to_level(interrupt));
            else if (end_of_ack || end_of_poll)
                acknowledged <= '0;
            if (interrupt != '0)
                interrupt_to_cpu <= 1'b1;
            else if (end_of_ack || end_of_poll)
                interrupt_to_cpu <= 1'b0;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        phase inside {pic_pkg::phase_ready, pic_pkg::phase_ack1,
                      pic_pkg::phase_ack2, pic_pkg::phase_poll});

endmodule

`default_nettype wire

/* design/pic_command_decode.sv */
// ****************************************
// PIC command decode
// Splits CPU writes into ICW and OCW strobes
// and follows the initialization sequence
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module pic_command_decode (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  write,
    input  wire logic                  a0,
    input  wire logic [7:0]            data_in,
    output logic                       icw1,
    output logic                       icw2,
    output logic                       icw4,
    output logic                       ocw1,
    output logic                       ocw2,
    output logic                       ocw3,
    output pic_pkg::command_word_t     command
);

    typedef enum logic [1:0] {init_idle, init_icw2, init_icw3, init_icw4} init_state_t;

    init_state_t init_state;
    init_state_t next_init_state;
    logic        single;
    logic        icw4_needed;
    logic        control_write;
    logic        data_write;

    assign control_write = write & ~a0 & ~data_in[pic_pkg::icw1_select_bit];
    assign data_write = write & a0;

    assign icw1 = write & ~a0 & data_in[pic_pkg::icw1_select_bit];
    assign icw2 = data_write & (init_state == init_icw2);
    assign icw4 = data_write & (init_state == init_icw4);
    assign ocw1 = data_write & (init_state == init_idle);
    assign ocw2 = control_write & ~data_in[pic_pkg::ocw3_select_bit] & (init_state == init_idle);
    assign ocw3 = control_write & data_in[pic_pkg::ocw3_select_bit] & (init_state == init_idle);

    assign command = data_in;

    // ICW3 byte is consumed here and goes nowhere
    always_comb begin
        next_init_state = init_state;
        if (icw1)
            next_init_state = init_icw2;
        else if (data_write) begin
            case (init_state)
                init_icw2: begin
                    if (!single)
                        next_init_state = init_icw3;
                    else
                        next_init_state = icw4_needed ? init_icw4 : init_idle;
                end
                init_icw3: next_init_state = icw4_needed ? init_icw4 : init_idle;
                default:   next_init_state = init_idle;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            init_state <= init_idle;
            single <= 1'b0;
            icw4_needed <= 1'b0;
        end else begin
            init_state <= next_init_state;
            if (icw1) begin
                single <= data_in[1];
                icw4_needed <= data_in[0];
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        $onehot0({icw1, icw2, icw4, ocw1, ocw2, ocw3}));

endmodule

`default_nettype wire

/* design/pic_control_logic.sv */
// ****************************************
// PIC control logic top
// Decode, execute and result stages of the controller
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module pic_control_logic (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       write,
    input  wire logic       a0,
    input  wire logic [7:0] data_in,
    input  wire logic       read,
    input  wire logic       interrupt_acknowledge_n,
    input  wire logic [7:0] interrupt,
    input  wire logic [7:0] highest_level_in_service,
    output logic [7:0]      data_out,
    output logic            data_out_enable,
    output logic            level_triggered,
    output logic            special_fully_nested,
    output logic            read_register_enable,
    output logic            read_register_isr,
    output logic [7:0]      interrupt_mask,
    output logic [2:0]      priority_rotate,
    output logic [7:0]      end_of_interrupt,
    output logic            freeze,
    output logic            latch_in_service,
    output logic [7:0]      clear_interrupt_request,
    output logic            interrupt_to_cpu
);

    logic                   icw1;
    logic                   icw2;
    logic                   icw4;
    logic                   ocw1;
    logic                   ocw2;
    logic                   ocw3;
    pic_pkg::command_word_t command;
    pic_pkg::ack_phase_t    phase;
    logic [7:0]             acknowledged;
    logic                   end_of_ack;
    logic [4:0]             vector_base;

    pic_command_decode i_pic_command_decode (
        .clock   (clock),
        .reset   (reset),
        .write   (write),
        .a0      (a0),
        .data_in (data_in),
        .icw1    (icw1),
        .icw2    (icw2),
        .icw4    (icw4),
        .ocw1    (ocw1),
        .ocw2    (ocw2),
        .ocw3    (ocw3),
        .command (command)
    );

    pic_mode_registers i_pic_mode_registers (
        .clock                    (clock),
        .reset                    (reset),
        .icw1                     (icw1),
        .icw2                     (icw2),
        .icw4                     (icw4),
        .ocw1                     (ocw1),
        .ocw2                     (ocw2),
        .ocw3                     (ocw3),
        .command                  (command),
        .end_of_ack               (end_of_ack),
        .acknowledged             (acknowledged),
        .highest_level_in_service (highest_level_in_service),
        .level_triggered          (level_triggered),
        .special_fully_nested     (special_fully_nested),
        .auto_eoi                 (),
        .vector_base              (vector_base),
        .interrupt_mask           (interrupt_mask),
        .priority_rotate          (priority_rotate),
        .read_register_enable     (read_register_enable),
        .read_register_isr        (read_register_isr),
        .end_of_interrupt         (end_of_interrupt)
    );

    pic_acknowledge_sequencer i_pic_acknowledge_sequencer (
        .clock                   (clock),
        .reset                   (reset),
        .icw1                    (icw1),
        .ocw3                    (ocw3),
        .ocw3_poll               (command.ocw3.poll),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .read                    (read),
        .interrupt               (interrupt),
        .phase                   (phase),
        .acknowledged            (acknowledged),
        .end_of_ack              (end_of_ack),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .latch_in_service        (latch_in_service),
        .freeze                  (freeze),
        .clear_interrupt_request (clear_interrupt_request)
    );

    pic_data_output i_pic_data_output (
        .phase                   (phase),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .read                    (read),
        .vector_base             (vector_base),
        .acknowledged            (acknowledged),
        .data_out                (data_out),
        .data_out_enable         (data_out_enable)
    );

endmodule

`default_nettype wire

/* design/pic_data_output.sv */
// ****************************************
// PIC data output
// Vector byte on the second INTA, poll word on read
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module pic_data_output (
    input  wire pic_pkg::ack_phase_t phase,
    input  wire logic                interrupt_acknowledge_n,
    input  wire logic                read,
    input  wire logic [4:0]          vector_base,
    input  wire logic [7:0]          acknowledged,
    output logic [7:0]               data_out,
    output logic                     data_out_enable
);

    logic [2:0] acknowledged_level;

    assign acknowledged_level = pic_pkg::onehot_to_level(acknowledged);

    always_comb begin
        data_out = '0;
        data_out_enable = 1'b0;
        if ((phase == pic_pkg::phase_ack2) && !interrupt_acknowledge_n) begin
            data_out_enable = 1'b1;
            data_out = {vector_base, acknowledged_level};
        end else if ((phase == pic_pkg::phase_poll) && read) begin
            data_out_enable = 1'b1;
            // Nothing pending reads as zero
            if (acknowledged != '0)
                data_out = pic_pkg::poll_status_flag | {5'b0, acknowledged_level};
        end
    end

    always_comb begin
        assert final (data_out_enable || (data_out == '0));
    end

endmodule

`default_nettype wire

/* design/pic_mode_registers.sv */
// ****************************************
// PIC mode registers
// Configuration, mask, rotation and read select,
// plus the end of interrupt pulse
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module pic_mode_registers (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   icw1,
    input  wire logic                   icw2,
    input  wire logic                   icw4,
    input  wire logic                   ocw1,
    input  wire logic                   ocw2,
    input  wire logic                   ocw3,
    input  wire pic_pkg::command_word_t command,
    input  wire logic                   end_of_ack,
    input  wire logic [7:0]             acknowledged,
    input  wire logic [7:0]             highest_level_in_service,
    output logic                        level_triggered,
    output logic                        special_fully_nested,
    output logic                        auto_eoi,
    output logic [4:0]                  vector_base,
    output logic [7:0]                  interrupt_mask,
    output logic [2:0]                  priority_rotate,
    output logic                        read_register_enable,
    output logic                        read_register_isr,
    output logic [7:0]                  end_of_interrupt
);

    logic [7:0] command_byte;
    logic [2:0] ocw2_action;
    logic       auto_rotate;

    assign command_byte = command;
    assign ocw2_action = {command.ocw2.rotate, command.ocw2.specific, command.ocw2.eoi};

    // ICW words
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            level_triggered <= 1'b0;
            vector_base <= '0;
            special_fully_nested <= 1'b0;
            auto_eoi <= 1'b0;
        end else if (icw1) begin
            level_triggered <= command_byte[pic_pkg::ltim_bit];
            vector_base <= '0;
            special_fully_nested <= 1'b0;
            auto_eoi <= 1'b0;
        end else if (icw2) begin
            vector_base <= command_byte[7:3];
        end else if (icw4) begin
            special_fully_nested <= command_byte[pic_pkg::sfnm_bit];
            auto_eoi <= command_byte[pic_pkg::aeoi_bit];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            interrupt_mask <= pic_pkg::mask_reset_value;
        else if (icw1)
            interrupt_mask <= pic_pkg::mask_reset_value;
        else if (ocw1)
            interrupt_mask <= command_byte;
    end

    // Rotation from OCW2, or after every acknowledge in auto-rotate
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            auto_rotate <= 1'b0;
            priority_rotate <= pic_pkg::rotate_reset_value;
        end else if (icw1) begin
            auto_rotate <= 1'b0;
            priority_rotate <= pic_pkg::rotate_reset_value;
        end else if (auto_rotate && end_of_ack) begin
            priority_rotate <= pic_pkg::onehot_to_level(acknowledged);
        end else if (ocw2) begin
            casez (ocw2_action)
                3'b000:  auto_rotate <= 1'b0;
                3'b100:  auto_rotate <= 1'b1;
                3'b101:  priority_rotate <= pic_pkg::onehot_to_level(highest_level_in_service);
                3'b11?:  priority_rotate <= command.ocw2.level;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            read_register_enable <= 1'b1;
            read_register_isr <= 1'b0;
        end else if (icw1) begin
            read_register_enable <= 1'b1;
            read_register_isr <= 1'b0;
        end else if (ocw3) begin
            read_register_enable <= command.ocw3.read_register;
            read_register_isr <= command.ocw3.read_isr;
        end
    end

    always_comb begin
        end_of_interrupt = '0;
        if (icw1)
            end_of_interrupt = '1;
        else if (auto_eoi && end_of_ack)
            end_of_interrupt = acknowledged;
        else if (ocw2 && command.ocw2.eoi) begin
            if (command.ocw2.specific)
                end_of_interrupt = pic_pkg::level_to_onehot(command.ocw2.level);
            else
                end_of_interrupt = highest_level_in_service;
        end
    end

    // Only the soft reset clears more than one level at once
    assert property (@(posedge clock) disable iff (reset)
        !icw1 |-> $onehot0(end_of_interrupt));

endmodule

`default_nettype wire

/* design/pic_pkg.sv */
// ****************************************
// PIC shared definitions
// Field positions, reset values, the command byte views,
// the acknowledge phase and level conversions
// ****************************************
`default_nettype none

package pic_pkg;

    localparam int num_levels = 8;
    localparam int level_width = 3;

    localparam logic [num_levels-1:0] mask_reset_value = '1;
    localparam logic [level_width-1:0] rotate_reset_value = 3'd7;

    // Bit positions inside command bytes
    localparam int icw1_select_bit = 4;
    localparam int ocw3_select_bit = 3;
    localparam int ltim_bit = 3;
    localparam int sfnm_bit = 4;
    localparam int aeoi_bit = 1;

    localparam logic [7:0] poll_status_flag = 8'h80;

    // Control byte with a0 low and D4 low, read as OCW2 or OCW3 by D3
    typedef union packed {
        struct packed {
            logic                   rotate;
            logic                   specific;
            logic                   eoi;
            logic [1:0]             select;
            logic [level_width-1:0] level;
        } ocw2;
        struct packed {
            logic       reserved;
            logic       esmm;
            logic       smm;
            logic [1:0] select;
            logic       poll;
            logic       read_register;
            logic       read_isr;
        } ocw3;
    } command_word_t;

    typedef enum logic [1:0] {
        phase_ready,
        phase_ack1,
        phase_ack2,
        phase_poll
    } ack_phase_t;

    function automatic logic [num_levels-1:0] level_to_onehot(
        input logic [level_width-1:0] level
    );
        return num_levels'(1) << level;
    endfunction

    // Lowest set bit wins
    function automatic logic [level_width-1:0] onehot_to_level(
        input logic [num_levels-1:0] onehot
    );
        logic [level_width-1:0] level;
        level = '0;
        for (int i = num_levels - 1; i >= 0; i--) begin
            if (onehot[i])
                level = level_width'(i);
        end
        return level;
    endfunction

endpackage

`default_nettype wire

/* files.f */
design/pic_pkg.sv
design/pic_command_decode.sv
design/pic_mode_registers.sv
design/pic_acknowledge_sequencer.sv
design/pic_data_output.sv
design/pic_control_logic.sv
sim/tb_pic_control_logic.sv

/* sim/pic_patterns.txt */
# op name field1 field2, fields in hex
# W a0 data | R interrupt in_service | A vector_base flags(1 aeoi, 2 rotate)
# P interrupt expected_byte | E command expected_eoi | C output expected
C reset_mask interrupt_mask ff
C reset_rotate priority_rotate 07
C reset_int interrupt_to_cpu 00
C reset_data_enable data_out_enable 00
C reset_read_select read_register_enable 01
W icw1_single 0 1b
W icw2_base 1 40
C icw2_not_mask interrupt_mask ff
W icw4_sfnm 1 11
W ocw1_mask 1 a5
C init_mask interrupt_mask a5
C init_ltim level_triggered 01
C init_sfnm special_fully_nested 01
A ack_1 40 00
A ack_2 40 00
A ack_3 40 00
E eoi_specific_3 63 08
E eoi_specific_6 66 40
R in_service_4 00 10
E eoi_nonspecific 20 10
E rotate_on_eoi a0 10
C rotate_to_4 priority_rotate 04
E set_priority_5 c5 00
C priority_5 priority_rotate 05
E icw1_soft_reset 11 ff
C icw1_mask interrupt_mask ff
C icw1_rotate priority_rotate 07
C icw1_ltim level_triggered 00
W icw2_base_48 1 48
W icw3_swallowed 1 3c
C icw3_not_mask interrupt_mask ff
W icw4_aeoi 1 03
W ocw1_clear 1 00
C mask_written interrupt_mask 00
C sfnm_cleared special_fully_nested 00
E auto_rotate_on 80 00
A aeoi_rotate_1 48 03
A aeoi_rotate_2 48 03
R clear_in_service 00 00
P poll_level_5 20 85
P poll_none 00 00
W ocw3_read_isr 0 0b
C rr_enable read_register_enable 01
C rr_isr read_register_isr 01
W ocw3_read_irr 0 0a
C rr_isr_clear read_register_isr 00

/* sim/tb_pic_control_logic.sv */
// ****************************************
// PIC control logic testbench
// Runs the pattern file against the controller
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_pic_control_logic;

    localparam int wait_limit = 50;

    logic        clock;
    logic        reset;
    logic        write;
    logic        a0;
    logic [7:0]  data_in;
    logic        read;
    logic        interrupt_acknowledge_n;
    logic [7:0]  interrupt;
    logic [7:0]  highest_level_in_service;
    logic [7:0]  data_out;
    logic        data_out_enable;
    logic        level_triggered;
    logic        special_fully_nested;
    logic        read_register_enable;
    logic        read_register_isr;
    logic [7:0]  interrupt_mask;
    logic [2:0]  priority_rotate;
    logic [7:0]  end_of_interrupt;
    logic        freeze;
    logic        latch_in_service;
    logic [7:0]  clear_interrupt_request;
    logic        interrupt_to_cpu;

    int          test_count;
    int          failed_tests;
    int          error_count;
    logic        aborted;
    logic [31:0] rng_state;

    pic_control_logic i_pic_control_logic (
        .clock                    (clock),
        .reset                    (reset),
        .write                    (write),
        .a0                       (a0),
        .data_in                  (data_in),
        .read                     (read),
        .interrupt_acknowledge_n  (interrupt_acknowledge_n),
        .interrupt                (interrupt),
        .highest_level_in_service (highest_level_in_service),
        .data_out                 (data_out),
        .data_out_enable          (data_out_enable),
        .level_triggered          (level_triggered),
        .special_fully_nested     (special_fully_nested),
        .read_register_enable     (read_register_enable),
        .read_register_isr        (read_register_isr),
        .interrupt_mask           (interrupt_mask),
        .priority_rotate          (priority_rotate),
        .end_of_interrupt         (end_of_interrupt),
        .freeze                   (freeze),
        .latch_in_service         (latch_in_service),
        .clear_interrupt_request  (clear_interrupt_request),
        .interrupt_to_cpu         (interrupt_to_cpu)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic write_register(input logic address, input logic [7:0] value);
        @(negedge clock);
        write = 1'b1;
        a0 = address;
        data_in = value;
        @(negedge clock);
        write = 1'b0;
    endtask

    task automatic set_requests(input logic [7:0] pending, input logic [7:0] in_service);
        @(negedge clock);
        interrupt = pending;
        highest_level_in_service = in_service;
    endtask

    // EOI pulse sampled inside the OCW2 or ICW1 write cycle
    task automatic write_expect_eoi(input string name, input logic [7:0] value,
                                    input logic [7:0] expected);
        @(negedge clock);
        write = 1'b1;
        a0 = 1'b0;
        data_in = value;
        #1;
        compare(name, expected, end_of_interrupt);
        @(negedge clock);
        write = 1'b0;
    endtask

    // flags bit 0 expects an automatic EOI, bit 1 an automatic rotation
    task automatic run_acknowledge(input string name, input logic [7:0] base,
                                   input logic [7:0] flags);
        logic [2:0] level;
        logic [7:0] onehot;
        int         waited;
        rng_state = xorshift(rng_state);
        level = rng_state[2:0];
        onehot = 8'b1 << level;
        @(negedge clock);
        interrupt = onehot;
        waited = 0;
        while (!interrupt_to_cpu && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (!interrupt_to_cpu) begin
            $display("Timeout in %s: interrupt_to_cpu never rose", name);
            aborted = 1'b1;
        end else begin
            interrupt_acknowledge_n = 1'b0;
            #1;
            compare({name, " latch"}, 8'h01, latch_in_service);
            compare({name, " clear"}, onehot, clear_interrupt_request);
            @(negedge clock);
            compare({name, " freeze"}, 8'h01, freeze);
            interrupt = '0;
            @(negedge clock);
            interrupt_acknowledge_n = 1'b1;
            @(negedge clock);
            interrupt_acknowledge_n = 1'b0;
            #1;
            compare({name, " enable"}, 8'h01, data_out_enable);
            compare({name, " vector"}, {base[7:3], level}, data_out);
            @(negedge clock);
            interrupt_acknowledge_n = 1'b1;
            #1;
            compare({name, " eoi"}, flags[0] ? onehot : 8'h00, end_of_interrupt);
            @(negedge clock);
            compare({name, " int"}, 8'h00, interrupt_to_cpu);
            compare({name, " release"}, 8'h00, freeze);
            if (flags[1])
                compare({name, " rotate"}, level, priority_rotate);
        end
    endtask

    task automatic run_poll(input string name, input logic [7:0] pending,
                            input logic [7:0] expected);
        @(negedge clock);
        interrupt = pending;
        @(negedge clock);
        write = 1'b1;
        a0 = 1'b0;
        data_in = 8'h0c;
        @(negedge clock);
        write = 1'b0;
        read = 1'b1;
        interrupt = '0;
        #1;
        compare({name, " enable"}, 8'h01, data_out_enable);
        compare({name, " byte"}, expected, data_out);
        @(negedge clock);
        read = 1'b0;
        @(negedge clock);
        compare({name, " int"}, 8'h00, interrupt_to_cpu);
    endtask

    task automatic check_output(input string name, input string signal,
                                input logic [7:0] expected);
        logic [7:0] actual;
        logic       known;
        known = 1'b1;
        actual = '0;
        @(negedge clock);
        #1;
        case (signal)
            "interrupt_mask":       actual = interrupt_mask;
            "priority_rotate":      actual = priority_rotate;
            "level_triggered":      actual = level_triggered;
            "special_fully_nested": actual = special_fully_nested;
            "read_register_enable": actual = read_register_enable;
            "read_register_isr":    actual = read_register_isr;
            "interrupt_to_cpu":     actual = interrupt_to_cpu;
            "data_out_enable":      actual = data_out_enable;
            default:                known = 1'b0;
        endcase
        if (known)
            compare(name, expected, actual);
        else begin
            $display("Test %s names an output the testbench does not know: %s", name, signal);
            error_count++;
        end
    endtask

    initial begin
        string      line;
        string      op;
        string      name;
        string      field1;
        string      field2;
        int         fd;
        int         code;
        int         errors_before;
        logic [7:0] value1;
        logic [7:0] value2;
        clock = 1'b0;
        reset = 1'b1;
        write = 1'b0;
        a0 = 1'b0;
        data_in = '0;
        read = 1'b0;
        interrupt_acknowledge_n = 1'b1;
        interrupt = '0;
        highest_level_in_service = '0;
        test_count = 0;
        failed_tests = 0;
        error_count = 0;
        aborted = 1'b0;
        rng_state = 32'd22;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        fd = $fopen("sim/pic_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file sim/pic_patterns.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                code = $sscanf(line, "%s %s %s %s", op, name, field1, field2);
                if (code != 4) begin
                    $display("Pattern line does not have four fields: %s", line);
                    error_count++;
                end else begin
                    value1 = '0;
                    value2 = '0;
                    code = $sscanf(field1, "%h", value1);
                    code = $sscanf(field2, "%h", value2);
                    errors_before = error_count;
                    case (op)
                        "W": write_register(value1[0], value2);
                        "R": set_requests(value1, value2);
                        "A": run_acknowledge(name, value1, value2);
                        "P": run_poll(name, value1, value2);
                        "E": write_expect_eoi(name, value1, value2);
                        "C": check_output(name, field1, value2);
                        default: begin
                            $display("Unknown operation %s in test %s", op, name);
                            error_count++;
                        end
                    endcase
                    if (op != "W" && op != "R") begin
                        test_count++;
                        if (aborted || error_count != errors_before) begin
                            failed_tests++;
                            $display("%-24s FAILED", name);
                        end else
                            $display("%-24s ok", name);
                    end
                end
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0 && failed_tests == 0 && !aborted) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
